// File: rt_pkg.sv
package rt_pkg;

	localparam int COORD_W = 16;
	localparam int FRAC_W = 8;
	localparam int RAY_ID_W = 8;

	localparam int LANE_DEPTH_DEF = 4;
	localparam int OUT_DEPTH_DEF = 8;
	localparam int DS_CREDITS_DEF = 4;

	// Signed Q8.8.
	typedef logic signed [COORD_W-1:0] coord_t;
	typedef logic [RAY_ID_W-1:0] ray_id_t;

	typedef struct packed {
		ray_id_t ray_id;
		logic is_shadow;
		coord_t origin_x;
		coord_t origin_y;
		coord_t origin_z;
		coord_t inv_dir_x;
		coord_t inv_dir_y;
		coord_t inv_dir_z;
	} ray_t;

	typedef struct packed {
		ray_id_t ray_id;
		logic is_shadow;
		coord_t tmin;
		coord_t tmax;
	} trav_entry_t;

	typedef struct packed {
		ray_id_t ray_id;
		coord_t tmax;
	} stack_entry_t;

	typedef struct packed {
		ray_id_t ray_id;
	} shade_entry_t;

endpackage: rt_pkg

// File: ray_queue.sv
`timescale 1ns/1ps

module ray_queue #(
	parameter type payload_t = logic,
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t pop_data,
	output logic empty,
	output logic [$clog2(DEPTH+1)-1:0] count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// Wraps at DEPTH, which need not be a power of two.
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// Head entry.
	assign pop_data = mem[rd_ptr];
	assign empty = (count == '0);

endmodule: ray_queue

// File: lane_arbiter.sv
`timescale 1ns/1ps

module lane_arbiter #(
	parameter int LANE_DEPTH = rt_pkg::LANE_DEPTH_DEF
) (
	input logic clk,
	input logic rst_n,
	input logic [1:0] lane_valid,
	input rt_pkg::ray_t lane_ray [2],
	output logic [1:0] lane_credit,
	input logic admit,
	output logic pipe_valid,
	output rt_pkg::ray_t pipe_ray
);

	import rt_pkg::*;

	ray_t q_data [2];
	logic [1:0] q_empty;
	logic [1:0] q_pop;
	logic last_grant;
	logic grant_any;
	logic grant_lane;

	// One buffer per lane, sized to the credits the lane holds.
	for (genvar i = 0; i < 2; i++) begin : g_lane
		ray_queue #(
			.payload_t(ray_t),
			.DEPTH(LANE_DEPTH)
		) lane_q (
			.clk,
			.rst_n,
			.push(lane_valid[i]),
			.push_data(lane_ray[i]),
			.pop(q_pop[i]),
			.pop_data(q_data[i]),
			.empty(q_empty[i]),
			.count()
		);
	end

	// The other lane goes first, then the one granted last.
	always_comb begin
		grant_any = 1'b0;
		grant_lane = ~last_grant;
		if (admit) begin
			if (!q_empty[~last_grant]) begin
				grant_any = 1'b1;
			end else if (!q_empty[last_grant]) begin
				grant_any = 1'b1;
				grant_lane = last_grant;
			end
		end
	end

	assign q_pop = grant_any ? (2'b01 << grant_lane) : 2'b00;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pipe_valid <= 1'b0;
			lane_credit <= 2'b00;
			last_grant <= 1'b1;
		end else begin
			pipe_valid <= grant_any;
			// Credit goes back the cycle after the pop.
			lane_credit <= q_pop;
			if (grant_any)
				last_grant <= grant_lane;
		end
	end

	always_ff @(posedge clk) begin
		if (grant_any)
			pipe_ray <= q_data[grant_lane];
	end

endmodule: lane_arbiter

// File: slab_test_pipe.sv
`timescale 1ns/1ps

module slab_test_pipe (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input rt_pkg::ray_t in_ray,
	input rt_pkg::coord_t box_min_x,
	input rt_pkg::coord_t box_min_y,
	input rt_pkg::coord_t box_min_z,
	input rt_pkg::coord_t box_max_x,
	input rt_pkg::coord_t box_max_y,
	input rt_pkg::coord_t box_max_z,
	output logic out_valid,
	output rt_pkg::ray_id_t out_id,
	output logic out_shadow,
	output rt_pkg::coord_t out_tmin,
	output rt_pkg::coord_t out_tmax,
	output logic out_miss
);

	import rt_pkg::*;

	coord_t box_min [3];
	coord_t box_max [3];
	coord_t origin [3];
	coord_t inv_dir [3];

	logic s1_valid;
	ray_id_t s1_id;
	logic s1_shadow;
	coord_t s1_t_lo [3];
	coord_t s1_t_hi [3];

	logic s2_valid;
	ray_id_t s2_id;
	logic s2_shadow;
	coord_t s2_near [3];
	coord_t s2_far [3];

	coord_t near_max;
	coord_t far_min;

	// (bound - origin) * inv_dir back in Q8.8, clamped to 16 bits.
	function automatic coord_t slab_dist(input coord_t bound, input coord_t org,
			input coord_t inv);
		logic signed [COORD_W:0] diff;
		logic signed [2*COORD_W:0] prod;
		logic signed [2*COORD_W:0] scaled;
		logic [COORD_W+1:0] upper;
		coord_t res;
		diff = bound - org;
		prod = diff * inv;
		scaled = prod >>> FRAC_W;
		upper = scaled[2*COORD_W:COORD_W-1];
		if (upper == '0 || upper == '1)
			res = scaled[COORD_W-1:0];
		else if (scaled[2*COORD_W])
			res = {1'b1, {(COORD_W-1){1'b0}}};
		else
			res = {1'b0, {(COORD_W-1){1'b1}}};
		return res;
	endfunction

	assign box_min = '{box_min_x, box_min_y, box_min_z};
	assign box_max = '{box_max_x, box_max_y, box_max_z};
	assign origin = '{in_ray.origin_x, in_ray.origin_y, in_ray.origin_z};
	assign inv_dir = '{in_ray.inv_dir_x, in_ray.inv_dir_y, in_ray.inv_dir_z};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			s2_valid <= s1_valid;
			out_valid <= s2_valid;
		end
	end

	// Stage 1, slab plane distances.
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_id <= in_ray.ray_id;
			s1_shadow <= in_ray.is_shadow;
			for (int a = 0; a < 3; a++) begin
				s1_t_lo[a] <= slab_dist(box_min[a], origin[a], inv_dir[a]);
				s1_t_hi[a] <= slab_dist(box_max[a], origin[a], inv_dir[a]);
			end
		end
	end

	// Stage 2, near and far per axis.
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2_id <= s1_id;
			s2_shadow <= s1_shadow;
			for (int a = 0; a < 3; a++) begin
				if (s1_t_lo[a] > s1_t_hi[a]) begin
					s2_near[a] <= s1_t_hi[a];
					s2_far[a] <= s1_t_lo[a];
				end else begin
					s2_near[a] <= s1_t_lo[a];
					s2_far[a] <= s1_t_hi[a];
				end
			end
		end
	end

	always_comb begin
		near_max = s2_near[0];
		far_min = s2_far[0];
		for (int a = 1; a < 3; a++) begin
			if (s2_near[a] > near_max)
				near_max = s2_near[a];
			if (s2_far[a] < far_min)
				far_min = s2_far[a];
		end
	end

	// Stage 3, interval and miss.
	always_ff @(posedge clk) begin
		if (s2_valid) begin
			out_id <= s2_id;
			out_shadow <= s2_shadow;
			out_tmin <= near_max;
			out_tmax <= far_min;
			out_miss <= (near_max > far_min) || (far_min < 0);
		end
	end

endmodule: slab_test_pipe

// File: scene_int.sv
`timescale 1ns/1ps

module scene_int #(
	parameter int OUT_DEPTH = rt_pkg::OUT_DEPTH_DEF,
	parameter int DS_CREDITS = rt_pkg::DS_CREDITS_DEF
) (
	input logic clk,
	input logic rst_n,
	input logic pipe_valid,
	input rt_pkg::ray_t pipe_ray,
	output logic admit,
	input rt_pkg::coord_t box_min_x,
	input rt_pkg::coord_t box_min_y,
	input rt_pkg::coord_t box_min_z,
	input rt_pkg::coord_t box_max_x,
	input rt_pkg::coord_t box_max_y,
	input rt_pkg::coord_t box_max_z,
	output logic trav_valid,
	output rt_pkg::trav_entry_t trav_data,
	input logic trav_credit,
	output logic stack_valid,
	output rt_pkg::stack_entry_t stack_data,
	input logic stack_credit,
	output logic shade_valid,
	output rt_pkg::shade_entry_t shade_data,
	input logic shade_credit
);

	import rt_pkg::*;

	localparam int CNT_W = $clog2(OUT_DEPTH + 1);
	localparam int OCC_W = $clog2(OUT_DEPTH + 5);
	localparam int CRD_W = $clog2(DS_CREDITS + 1);

	logic res_valid;
	ray_id_t res_id;
	logic res_shadow;
	coord_t res_tmin;
	coord_t res_tmax;
	logic res_miss;
	logic hit_push;
	logic miss_push;
	logic [1:0] in_flight;
	logic [OCC_W-1:0] pending;
	trav_entry_t trav_in;
	stack_entry_t stack_in;
	shade_entry_t shade_in;
	logic [CNT_W-1:0] trav_count;
	logic [CNT_W-1:0] stack_count;
	logic [CNT_W-1:0] shade_count;
	// Port order is trav, stack, shade.
	logic [2:0] q_empty;
	logic [2:0] port_valid;
	logic [2:0] port_credit;
	logic [CRD_W-1:0] credits [3];

	function automatic logic has_room(input logic [CNT_W-1:0] count,
			input logic [OCC_W-1:0] pend);
		logic [OCC_W-1:0] occ;
		occ = OCC_W'(count) + pend;
		return occ < OCC_W'(OUT_DEPTH);
	endfunction

	slab_test_pipe slab_pipe (
		.clk,
		.rst_n,
		.in_valid(pipe_valid),
		.in_ray(pipe_ray),
		.box_min_x,
		.box_min_y,
		.box_min_z,
		.box_max_x,
		.box_max_y,
		.box_max_z,
		.out_valid(res_valid),
		.out_id(res_id),
		.out_shadow(res_shadow),
		.out_tmin(res_tmin),
		.out_tmax(res_tmax),
		.out_miss(res_miss)
	);

	// Rays already admitted but not yet written to a queue.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			in_flight <= '0;
		else if (pipe_valid && !res_valid)
			in_flight <= in_flight + 1'b1;
		else if (res_valid && !pipe_valid)
			in_flight <= in_flight - 1'b1;
	end

	assign pending = OCC_W'(in_flight) + OCC_W'(pipe_valid);
	assign admit = has_room(trav_count, pending) && has_room(stack_count, pending) &&
		has_room(shade_count, pending);

	assign hit_push = res_valid && !res_miss;
	assign miss_push = res_valid && res_miss;
	assign trav_in = '{ray_id: res_id, is_shadow: res_shadow, tmin: res_tmin, tmax: res_tmax};
	assign stack_in = '{ray_id: res_id, tmax: res_tmax};
	assign shade_in = '{ray_id: res_id};

	ray_queue #(.payload_t(trav_entry_t), .DEPTH(OUT_DEPTH)) trav_q (
		.clk, .rst_n,
		.push(hit_push), .push_data(trav_in),
		.pop(port_valid[0]), .pop_data(trav_data),
		.empty(q_empty[0]), .count(trav_count)
	);

	ray_queue #(.payload_t(stack_entry_t), .DEPTH(OUT_DEPTH)) stack_q (
		.clk, .rst_n,
		.push(hit_push), .push_data(stack_in),
		.pop(port_valid[1]), .pop_data(stack_data),
		.empty(q_empty[1]), .count(stack_count)
	);

	ray_queue #(.payload_t(shade_entry_t), .DEPTH(OUT_DEPTH)) shade_q (
		.clk, .rst_n,
		.push(miss_push), .push_data(shade_in),
		.pop(port_valid[2]), .pop_data(shade_data),
		.empty(q_empty[2]), .count(shade_count)
	);

	assign port_credit = {shade_credit, stack_credit, trav_credit};

	// A valid cycle spends one credit.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int p = 0; p < 3; p++)
				credits[p] <= CRD_W'(DS_CREDITS);
		end else begin
			for (int p = 0; p < 3; p++) begin
				if (port_valid[p] && !port_credit[p])
					credits[p] <= credits[p] - 1'b1;
				else if (port_credit[p] && !port_valid[p])
					credits[p] <= credits[p] + 1'b1;
			end
		end
	end

	always_comb begin
		for (int p = 0; p < 3; p++)
			port_valid[p] = !q_empty[p] && (credits[p] != '0);
	end

	assign trav_valid = port_valid[0];
	assign stack_valid = port_valid[1];
	assign shade_valid = port_valid[2];

endmodule: scene_int

// File: rt_top.sv
`timescale 1ns/1ps

module rt_top #(
	parameter int LANE_DEPTH = rt_pkg::LANE_DEPTH_DEF,
	parameter int OUT_DEPTH = rt_pkg::OUT_DEPTH_DEF,
	parameter int DS_CREDITS = rt_pkg::DS_CREDITS_DEF
) (
	input logic clk,
	input logic rst_n,
	input logic [1:0] lane_valid,
	input rt_pkg::ray_t lane_ray [2],
	output logic [1:0] lane_credit,
	input rt_pkg::coord_t box_min_x,
	input rt_pkg::coord_t box_min_y,
	input rt_pkg::coord_t box_min_z,
	input rt_pkg::coord_t box_max_x,
	input rt_pkg::coord_t box_max_y,
	input rt_pkg::coord_t box_max_z,
	output logic trav_valid,
	output rt_pkg::trav_entry_t trav_data,
	input logic trav_credit,
	output logic stack_valid,
	output rt_pkg::stack_entry_t stack_data,
	input logic stack_credit,
	output logic shade_valid,
	output rt_pkg::shade_entry_t shade_data,
	input logic shade_credit
);

	import rt_pkg::*;

	logic admit;
	logic pipe_valid;
	ray_t pipe_ray;

	lane_arbiter #(.LANE_DEPTH(LANE_DEPTH)) arb (
		.clk,
		.rst_n,
		.lane_valid,
		.lane_ray,
		.lane_credit,
		.admit,
		.pipe_valid,
		.pipe_ray
	);

	scene_int #(.OUT_DEPTH(OUT_DEPTH), .DS_CREDITS(DS_CREDITS)) sint (
		.clk,
		.rst_n,
		.pipe_valid,
		.pipe_ray,
		.admit,
		.box_min_x,
		.box_min_y,
		.box_min_z,
		.box_max_x,
		.box_max_y,
		.box_max_z,
		.trav_valid,
		.trav_data,
		.trav_credit,
		.stack_valid,
		.stack_data,
		.stack_credit,
		.shade_valid,
		.shade_data,
		.shade_credit
	);

endmodule: rt_top

// File: tb_rt_top.sv
`timescale 1ns/1ps

module tb_rt_top;

	import rt_pkg::*;

	localparam int LANE_DEPTH = LANE_DEPTH_DEF;
	localparam int OUT_DEPTH = OUT_DEPTH_DEF;
	localparam int DS_CREDITS = DS_CREDITS_DEF;
	localparam int MAX_RAYS = 64;
	localparam int TIMEOUT = 5000;
	localparam int HOLD_CYCLES = 150;

	logic clk;
	logic rst_n;
	logic [1:0] lane_valid;
	ray_t lane_ray [2];
	logic [1:0] lane_credit;
	coord_t box_min_x;
	coord_t box_min_y;
	coord_t box_min_z;
	coord_t box_max_x;
	coord_t box_max_y;
	coord_t box_max_z;
	logic trav_valid;
	trav_entry_t trav_data;
	logic trav_credit;
	logic stack_valid;
	stack_entry_t stack_data;
	logic stack_credit;
	logic shade_valid;
	shade_entry_t shade_data;
	logic shade_credit;

	// Scoreboard indexed by ray id.
	bit exp_known [256];
	bit exp_miss [256];
	bit exp_shadow [256];
	coord_t exp_tmin [256];
	coord_t exp_tmax [256];
	int exp_lane [256];
	int exp_seq [256];
	int seen [3][256];
	int last_seq [3][2];
	int port_count [3];
	int hold_valids [3];
	string port_name [3] = '{"trav", "stack", "shade"};

	ray_t rays [2][MAX_RAYS];
	int n_rays [2];
	int n_hits;
	int n_miss;
	int lane_sent [2];
	int lane_returned [2];
	int lane_cred [2];
	int credit_pulses [2];
	int value_errs;
	int proto_errs;
	bit hold_credits;
	bit any_sent;
	bit file_ok;

	rt_top #(
		.LANE_DEPTH(LANE_DEPTH),
		.OUT_DEPTH(OUT_DEPTH),
		.DS_CREDITS(DS_CREDITS)
	) DUT (
		.clk,
		.rst_n,
		.lane_valid,
		.lane_ray,
		.lane_credit,
		.box_min_x,
		.box_min_y,
		.box_min_z,
		.box_max_x,
		.box_max_y,
		.box_max_z,
		.trav_valid,
		.trav_data,
		.trav_credit,
		.stack_valid,
		.stack_data,
		.stack_credit,
		.shade_valid,
		.shade_data,
		.shade_credit
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic read_stimulus();
		int fd;
		int n;
		int lane;
		int id;
		int shd;
		int ox;
		int oy;
		int oz;
		int ix;
		int iy;
		int iz;
		int tmn;
		int tmx;
		int ms;
		bit have_box;
		string line;
		ray_t r;
		have_box = 1'b0;
		file_ok = 1'b0;
		fd = $fopen("rt_top_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file rt_top_stimulus.txt");
			proto_errs++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if (!have_box) begin
				n = $sscanf(line, "%d %d %d %d %d %d", ox, oy, oz, ix, iy, iz);
				if (n != 6) begin
					$display("The box line of the stimulus file is malformed");
					proto_errs++;
					return;
				end
				box_min_x = coord_t'(ox);
				box_min_y = coord_t'(oy);
				box_min_z = coord_t'(oz);
				box_max_x = coord_t'(ix);
				box_max_y = coord_t'(iy);
				box_max_z = coord_t'(iz);
				have_box = 1'b1;
				continue;
			end
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
				lane, id, shd, ox, oy, oz, ix, iy, iz, tmn, tmx, ms);
			if (n != 12 || lane < 0 || lane > 1 || n_rays[lane] >= MAX_RAYS) begin
				$display("Skipping a malformed ray line in the stimulus file");
				proto_errs++;
				continue;
			end
			r.ray_id = ray_id_t'(id);
			r.is_shadow = shd[0];
			r.origin_x = coord_t'(ox);
			r.origin_y = coord_t'(oy);
			r.origin_z = coord_t'(oz);
			r.inv_dir_x = coord_t'(ix);
			r.inv_dir_y = coord_t'(iy);
			r.inv_dir_z = coord_t'(iz);
			exp_known[id[7:0]] = 1'b1;
			exp_shadow[id[7:0]] = shd[0];
			exp_miss[id[7:0]] = ms[0];
			exp_tmin[id[7:0]] = coord_t'(tmn);
			exp_tmax[id[7:0]] = coord_t'(tmx);
			exp_lane[id[7:0]] = lane;
			exp_seq[id[7:0]] = n_rays[lane];
			rays[lane][n_rays[lane]] = r;
			n_rays[lane]++;
			if (ms != 0)
				n_miss++;
			else
				n_hits++;
		end
		$fclose(fd);
		if (!have_box || n_rays[0] + n_rays[1] == 0) begin
			$display("The stimulus file holds no box or no rays");
			proto_errs++;
		end
		file_ok = have_box;
	endtask

	// Routing, duplicate and per-lane order checks shared by all ports.
	task automatic note_arrival(input int p, input int id, input bit want_miss, output bit ok);
		int l;
		ok = 1'b0;
		if (!exp_known[id]) begin
			$display("The %s port delivered ray %0d, which was never sent", port_name[p], id);
			proto_errs++;
		end else if (exp_miss[id] != want_miss) begin
			$display("Ray %0d came out on the %s port against its hit result", id, port_name[p]);
			proto_errs++;
		end else begin
			ok = 1'b1;
			seen[p][id]++;
			if (seen[p][id] > 1) begin
				$display("Ray %0d appeared more than once on the %s port", id, port_name[p]);
				proto_errs++;
			end
			l = exp_lane[id];
			if (exp_seq[id] <= last_seq[p][l]) begin
				$display("Ray %0d of lane %0d left the %s port out of order", id, l,
					port_name[p]);
				proto_errs++;
			end
			last_seq[p][l] = exp_seq[id];
		end
	endtask

	task automatic check_trav(input trav_entry_t got);
		bit ok;
		note_arrival(0, got.ray_id, 1'b0, ok);
		if (ok) begin
			if (got.is_shadow !== exp_shadow[got.ray_id]) begin
				$display("ERR t=%0t trav_data.is_shadow id=%0d exp=%0b got=%0b", $time,
					got.ray_id, exp_shadow[got.ray_id], got.is_shadow);
				value_errs++;
			end
			if (got.tmin !== exp_tmin[got.ray_id]) begin
				$display("ERR t=%0t trav_data.tmin id=%0d exp=%0d got=%0d", $time,
					got.ray_id, exp_tmin[got.ray_id], got.tmin);
				value_errs++;
			end
			if (got.tmax !== exp_tmax[got.ray_id]) begin
				$display("ERR t=%0t trav_data.tmax id=%0d exp=%0d got=%0d", $time,
					got.ray_id, exp_tmax[got.ray_id], got.tmax);
				value_errs++;
			end
		end
	endtask

	task automatic check_stack(input stack_entry_t got);
		bit ok;
		note_arrival(1, got.ray_id, 1'b0, ok);
		if (ok && got.tmax !== exp_tmax[got.ray_id]) begin
			$display("ERR t=%0t stack_data.tmax id=%0d exp=%0d got=%0d", $time,
				got.ray_id, exp_tmax[got.ray_id], got.tmax);
			value_errs++;
		end
	endtask

	task automatic check_shade(input shade_entry_t got);
		bit ok;
		note_arrival(2, got.ray_id, 1'b1, ok);
	endtask

	// Sends one lane's rays while it holds credits.
	task automatic drive_lane(input int l);
		int idx;
		int gap;
		int cycles;
		idx = 0;
		gap = 0;
		cycles = 0;
		lane_cred[l] = LANE_DEPTH;
		while (idx < n_rays[l] || lane_returned[l] < lane_sent[l]) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				$display("Lane %0d timed out with %0d of %0d credits back", l,
					lane_returned[l], lane_sent[l]);
				proto_errs++;
				lane_valid[l] = 1'b0;
				return;
			end
			if (lane_credit[l]) begin
				lane_cred[l]++;
				lane_returned[l]++;
				if (lane_cred[l] > LANE_DEPTH) begin
					$display("Lane %0d got back more credits than it spent", l);
					proto_errs++;
				end
			end
			lane_valid[l] = 1'b0;
			if (gap > 0) begin
				gap--;
			end else if (idx < n_rays[l] && lane_cred[l] > 0) begin
				lane_valid[l] = 1'b1;
				lane_ray[l] = rays[l][idx];
				idx++;
				lane_cred[l]--;
				lane_sent[l]++;
				any_sent = 1'b1;
				gap = $urandom % 3;
			end
		end
	endtask

	task automatic consume_port(input int p);
		int owed;
		int delay;
		bit v;
		bit give;
		owed = 0;
		delay = 0;
		forever begin
			@(negedge clk);
			case (p)
				0: v = trav_valid;
				1: v = stack_valid;
				default: v = shade_valid;
			endcase
			if (v) begin
				case (p)
					0: check_trav(trav_data);
					1: check_stack(stack_data);
					default: check_shade(shade_data);
				endcase
				owed++;
				port_count[p]++;
				if (hold_credits) begin
					hold_valids[p]++;
					if (hold_valids[p] > DS_CREDITS) begin
						$display("The %s port sent without a credit", port_name[p]);
						proto_errs++;
					end
				end
			end
			give = 1'b0;
			if (delay > 0) begin
				delay--;
			end else if (owed > 0 && !hold_credits) begin
				give = 1'b1;
				owed--;
				delay = $urandom % 4;
			end
			case (p)
				0: trav_credit = give;
				1: stack_credit = give;
				default: shade_credit = give;
			endcase
		end
	endtask

	task automatic release_credits();
		repeat (HOLD_CYCLES) @(posedge clk);
		hold_credits = 1'b0;
	endtask

	// Nothing may come out before the first ray goes in.
	// Every lane credit pulse is counted over the whole run.
	always @(negedge clk) begin
		if (rst_n && !any_sent) begin
			if (trav_valid || stack_valid || shade_valid || lane_credit != 2'b00) begin
				$display("An output went active at %0t before any ray was sent", $time);
				proto_errs++;
			end
		end
		for (int l = 0; l < 2; l++) begin
			if (rst_n && lane_credit[l])
				credit_pulses[l]++;
		end
	end

	initial begin
		int cycles;
		void'($urandom(32'h916b_3fdb));
		rst_n = 1'b0;
		lane_valid = 2'b00;
		lane_ray[0] = '0;
		lane_ray[1] = '0;
		box_min_x = '0;
		box_min_y = '0;
		box_min_z = '0;
		box_max_x = '0;
		box_max_y = '0;
		box_max_z = '0;
		trav_credit = 1'b0;
		stack_credit = 1'b0;
		shade_credit = 1'b0;
		hold_credits = 1'b1;
		for (int p = 0; p < 3; p++) begin
			last_seq[p][0] = -1;
			last_seq[p][1] = -1;
		end
		read_stimulus();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		if (file_ok) begin
			repeat (5) @(negedge clk);
			fork
				consume_port(0);
				consume_port(1);
				consume_port(2);
			join_none
			fork
				drive_lane(0);
				drive_lane(1);
				release_credits();
			join
			cycles = 0;
			while (port_count[0] < n_hits || port_count[1] < n_hits ||
					port_count[2] < n_miss) begin
				@(posedge clk);
				cycles++;
				if (cycles > TIMEOUT) begin
					$display("Timed out waiting for the output entries");
					proto_errs++;
					break;
				end
			end
			// Leave room for stray duplicates to show up.
			repeat (20) @(posedge clk);
			for (int id = 0; id < 256; id++) begin
				if (exp_known[id] && !exp_miss[id] &&
						(seen[0][id] != 1 || seen[1][id] != 1)) begin
					$display("Hit ray %0d was not delivered once on trav and stack", id);
					proto_errs++;
				end
				if (exp_known[id] && exp_miss[id] && seen[2][id] != 1) begin
					$display("Missed ray %0d was not delivered once on shade", id);
					proto_errs++;
				end
			end
			for (int l = 0; l < 2; l++) begin
				if (lane_sent[l] != n_rays[l] || lane_returned[l] != lane_sent[l] ||
						credit_pulses[l] != lane_sent[l] || lane_cred[l] != LANE_DEPTH) begin
					$display("Lane %0d sent %0d of %0d rays, saw %0d credit pulses, holds %0d",
						l, lane_sent[l], n_rays[l], credit_pulses[l], lane_cred[l]);
					proto_errs++;
				end
			end
		end
		$display("Rays %0d, value errors %0d, protocol errors %0d",
			n_rays[0] + n_rays[1], value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule: tb_rt_top

// File: rt_top.f
rt_pkg.sv
ray_queue.sv
lane_arbiter.sv
slab_test_pipe.sv
scene_int.sv
rt_top.sv
tb_rt_top.sv

// File: Bender.yml
package:
  name: rt_top

sources:
  - files:
      - rt_pkg.sv
      - ray_queue.sv
      - lane_arbiter.sv
      - slab_test_pipe.sv
      - scene_int.sv
      - rt_top.sv
  - target: test
    files:
      - tb_rt_top.sv

// File: rt_top_stimulus.txt
# box: min_x min_y min_z max_x max_y max_z, raw Q8.8 integers
# ray: lane id shadow org_x org_y org_z inv_x inv_y inv_z exp_tmin exp_tmax exp_miss
-512 -512 -512 512 512 512
0 1 0 -1024 0 0 256 32767 32767 512 1536 0
0 2 1 0 0 0 256 256 256 -512 512 0
0 3 0 -1024 1024 0 256 32767 32767 512 -32768 1
0 4 0 1024 0 0 256 32767 32767 -1536 -512 1
0 5 1 -768 -768 -768 128 128 128 128 640 0
0 6 0 1024 0 0 -256 32767 32767 512 1536 0
0 7 1 0 0 0 512 512 512 -1024 1024 0
1 16 0 0 -1024 0 32767 256 32767 512 1536 0
1 17 1 0 0 -1280 32767 32767 512 1536 3584 0
1 18 0 768 768 0 -256 -256 32767 256 1280 0
1 19 0 0 -1024 1024 32767 256 32767 512 -32768 1
1 20 1 256 256 256 256 256 256 -768 256 0
1 21 0 -1024 -1536 0 256 512 32767 2048 1536 1
1 22 0 0 0 0 -512 256 256 -512 512 0
